/* hdl/cdr_pkg.sv */
`default_nettype none

package cdr_pkg;

    // adc sample domain
    localparam int ADC_W = 8;
    typedef logic signed [ADC_W-1:0] adc_code_t;  // range [-128, +127]

    // phase detector output, four terms of +-256 plus offset
    localparam int PD_W = 12;
    typedef logic signed [PD_W-1:0] pd_val_t;

    // loop filter integrator and interpolator code
    localparam int ACC_W = 20;
    typedef logic signed [ACC_W-1:0] acc_t;
    localparam int PI_FRAC = 8;                    // fraction bits below the pi code
    typedef logic [7:0] pi_code_t;                 // wraps mod 256
    typedef logic [3:0] shift_t;                   // gain as right shift

    // register port
    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      we;
    } reg_req_t;                                   // 21 bits

    // register map
    localparam reg_addr_t ADDR_OFFSET0 = 4'd0;     // 0..3 per group pd offset
    localparam reg_addr_t ADDR_THRESH0 = 4'd4;     // 4..7 per group slicer threshold
    localparam reg_addr_t ADDR_GAIN    = 4'd8;     // kp in 3:0, ki in 7:4
    localparam reg_addr_t ADDR_CTRL    = 4'd9;     // loop_en in bit 0
    localparam reg_addr_t ADDR_PI0     = 4'd10;    // 10..13 pi code readback

    // four clock groups in the register map
    localparam int CFG_GRP = 4;

    typedef struct packed {
        adc_code_t [CFG_GRP-1:0] pd_offset;
        adc_code_t [CFG_GRP-1:0] slice_thresh;
        shift_t                  kp_shift;
        shift_t                  ki_shift;
        logic                    loop_en;
    } cdr_cfg_t;                                   // 73 bits

endpackage

`default_nettype wire

/* hdl/data_slicer.sv */
`default_nettype none

module data_slicer #(
    parameter int NTI  = 16,
    parameter int NGRP = 4
) (
    input  wire logic                             clk,
    input  wire logic                             ext_rstb,
    input  wire logic                             in_valid,
    input  wire cdr_pkg::adc_code_t               codes [NTI],   // codes[0] earliest
    input  wire cdr_pkg::adc_code_t [NGRP-1:0]    slice_thresh,  // per clock group
    output logic                                  dec_valid,
    output cdr_pkg::adc_code_t                    dec_codes [NTI],
    output logic [NTI-1:0]                        dec_bits
);
    import cdr_pkg::*;

    logic [NTI-1:0] bits_next;  // decisions of the incoming batch

    // slice s sits in group s mod NGRP
    always_comb begin
        for (int s = 0; s < NTI; s++) begin
            bits_next[s] = ($signed(codes[s]) >= $signed(slice_thresh[s % NGRP]));
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;  // one cycle behind the adc strobe
        end
    end

    // codes travel with their bits so the detector sees them aligned
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_codes <= codes;
            dec_bits  <= bits_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/mm_pd.sv */
`default_nettype none

module mm_pd #(
    parameter int NTI  = 16,
    parameter int NGRP = 4
) (
    input  wire logic                             clk,
    input  wire logic                             ext_rstb,
    input  wire logic                             dec_valid,
    input  wire cdr_pkg::adc_code_t               dec_codes [NTI],
    input  wire logic [NTI-1:0]                   dec_bits,
    input  wire cdr_pkg::adc_code_t [NGRP-1:0]    pd_offset,
    output logic                                  pd_valid,
    output cdr_pkg::pd_val_t                      pd_out [NGRP]
);
    import cdr_pkg::*;

    localparam logic signed [1:0] A_POS = 2'sb01;  // +1
    localparam logic signed [1:0] A_NEG = 2'sb11;  // -1

    // window of the previous edge bit and the current batch with the incoming one as next
    logic           prev_edge_bit;     // bit NTI-1 of the previous batch
    adc_code_t      cur_codes [NTI];
    logic [NTI-1:0] cur_bits;
    logic           cur_full;          // current slot holds a real batch
    logic           prev_full;         // previous slot holds a real batch

    // data signs where ak[s+1] stands for slice s of the current batch
    logic signed [1:0] ak [NTI+2];
    logic signed [2:0] ak_diff [NTI];  // a[s+1] - a[s-1] takes -2, 0 or +2
    pd_val_t           term [NTI];
    pd_val_t           pd_sum [NGRP];

    always_comb begin
        ak[0] = prev_edge_bit ? A_POS : A_NEG;    // s-1 = -1 wraps to previous batch
        for (int s = 0; s < NTI; s++) begin
            ak[s+1] = cur_bits[s] ? A_POS : A_NEG;
        end
        ak[NTI+1] = dec_bits[0] ? A_POS : A_NEG;  // s+1 = NTI wraps to next batch
    end

    // per slice mm term code[s] * (a[s+1] - a[s-1])
    always_comb begin
        for (int s = 0; s < NTI; s++) begin
            ak_diff[s] = ak[s+2] - ak[s];
            term[s]    = pd_val_t'(cur_codes[s]) * pd_val_t'(ak_diff[s]);
        end
    end

    // group g collects slices g, g+NGRP, ... plus its own offset
    always_comb begin
        for (int g = 0; g < NGRP; g++) begin
            pd_sum[g] = pd_val_t'($signed(pd_offset[g]));
            for (int s = g; s < NTI; s += NGRP) begin
                pd_sum[g] = pd_sum[g] + term[s];
            end
        end
    end

    // history advances only on a decided batch
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            prev_edge_bit <= 1'b0;
            cur_bits      <= '0;
            cur_full      <= 1'b0;
            prev_full     <= 1'b0;
            pd_valid      <= 1'b0;
        end else begin
            pd_valid <= dec_valid && prev_full;  // the first two batches only prime the window
            if (dec_valid) begin
                prev_edge_bit <= cur_bits[NTI-1];
                cur_bits      <= dec_bits;
                cur_full      <= 1'b1;
                prev_full     <= cur_full;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            cur_codes <= dec_codes;
        end
        if (dec_valid && prev_full) begin
            pd_out <= pd_sum;  // result for the batch leaving the current slot
        end
    end

endmodule

`default_nettype wire

/* hdl/loop_filter.sv */
`default_nettype none

module loop_filter #(
    parameter int NGRP = 4
) (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire logic                 pd_valid,
    input  wire cdr_pkg::pd_val_t     pd_out [NGRP],
    input  wire cdr_pkg::shift_t      kp_shift,
    input  wire cdr_pkg::shift_t      ki_shift,
    input  wire logic                 loop_en,
    output logic                      pi_valid,
    output cdr_pkg::pi_code_t         pi_code [NGRP]
);
    import cdr_pkg::*;

    acc_t integ [NGRP];       // integral path state
    acc_t pd_ext [NGRP];      // sign extended phase error
    acc_t integ_next [NGRP];
    acc_t pi_sum [NGRP];      // integral plus proportional, fraction still attached

    always_comb begin
        for (int g = 0; g < NGRP; g++) begin
            pd_ext[g]     = acc_t'(pd_out[g]);
            integ_next[g] = integ[g] + (pd_ext[g] >>> ki_shift);
            pi_sum[g]     = integ_next[g] + (pd_ext[g] >>> kp_shift);  // uses updated integ
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pi_valid <= 1'b0;
            for (int g = 0; g < NGRP; g++) begin
                integ[g]   <= '0;
                pi_code[g] <= '0;
            end
        end else begin
            pi_valid <= pd_valid;  // pulses even with the loop open
            if (pd_valid && loop_en) begin
                for (int g = 0; g < NGRP; g++) begin
                    integ[g]   <= integ_next[g];
                    pi_code[g] <= pi_sum[g][PI_FRAC +: $bits(pi_code_t)];  // wraps mod 256
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cdr_regs.sv */
`default_nettype none

module cdr_regs #(
    parameter int NGRP = 4
) (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire logic                 reg_valid,
    input  wire cdr_pkg::reg_req_t    reg_req,
    input  wire cdr_pkg::pi_code_t    pi_code [NGRP],
    output cdr_pkg::cdr_cfg_t         cfg,
    output logic                      rvalid,
    output cdr_pkg::reg_data_t        rdata
);
    import cdr_pkg::*;

    reg_data_t rd_mux;   // read data for the requested address
    logic      wr_en;

    assign wr_en = reg_valid && reg_req.we;

    // write decode, takes effect on the request edge
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            cfg <= '0;  // loop open, zero offsets and thresholds
        end else if (wr_en) begin
            for (int g = 0; g < NGRP; g++) begin
                if (reg_req.addr == reg_addr_t'(ADDR_OFFSET0 + g)) begin
                    cfg.pd_offset[g] <= reg_req.wdata[ADC_W-1:0];
                end
                if (reg_req.addr == reg_addr_t'(ADDR_THRESH0 + g)) begin
                    cfg.slice_thresh[g] <= reg_req.wdata[ADC_W-1:0];
                end
            end
            if (reg_req.addr == ADDR_GAIN) begin
                cfg.kp_shift <= reg_req.wdata[3:0];
                cfg.ki_shift <= reg_req.wdata[7:4];
            end
            if (reg_req.addr == ADDR_CTRL) begin
                cfg.loop_en <= reg_req.wdata[0];
            end
        end
    end

    // read mux, unused bits and unmapped addresses give zero
    always_comb begin
        rd_mux = '0;
        for (int g = 0; g < NGRP; g++) begin
            if (reg_req.addr == reg_addr_t'(ADDR_OFFSET0 + g)) rd_mux = {8'h00, cfg.pd_offset[g]};
            if (reg_req.addr == reg_addr_t'(ADDR_THRESH0 + g)) rd_mux = {8'h00, cfg.slice_thresh[g]};
            if (reg_req.addr == reg_addr_t'(ADDR_PI0 + g))     rd_mux = {8'h00, pi_code[g]};
        end
        if (reg_req.addr == ADDR_GAIN) rd_mux = {8'h00, cfg.ki_shift, cfg.kp_shift};
        if (reg_req.addr == ADDR_CTRL) rd_mux = {15'h0000, cfg.loop_en};
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= reg_valid && !reg_req.we;  // reads answer next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reg_valid && !reg_req.we) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hdl/cdr_top.sv */
`default_nettype none

module cdr_top #(
    parameter int NTI  = 16,
    parameter int NGRP = 4
) (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    // adc batch stream, no stall
    input  wire logic                 in_valid,
    input  wire cdr_pkg::adc_code_t   codes [NTI],
    // register port
    input  wire logic                 reg_valid,
    input  wire cdr_pkg::reg_req_t    reg_req,
    output logic                      rvalid,
    output cdr_pkg::reg_data_t        rdata,
    // detector and interpolator outputs
    output logic                      pd_valid,
    output cdr_pkg::pd_val_t          pd_out [NGRP],
    output logic                      pi_valid,
    output cdr_pkg::pi_code_t         pi_code [NGRP]
);
    import cdr_pkg::*;

    cdr_cfg_t       cfg;
    logic           dec_valid;
    adc_code_t      dec_codes [NTI];
    logic [NTI-1:0] dec_bits;

    cdr_regs #(.NGRP(NGRP)) cdr_regs_i (
        .clk       (clk),
        .ext_rstb  (ext_rstb),
        .reg_valid (reg_valid),
        .reg_req   (reg_req),
        .pi_code   (pi_code),   // readback of the live pi codes
        .cfg       (cfg),
        .rvalid    (rvalid),
        .rdata     (rdata)
    );

    data_slicer #(.NTI(NTI), .NGRP(NGRP)) data_slicer_i (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .in_valid     (in_valid),
        .codes        (codes),
        .slice_thresh (cfg.slice_thresh),
        .dec_valid    (dec_valid),
        .dec_codes    (dec_codes),
        .dec_bits     (dec_bits)
    );

    mm_pd #(.NTI(NTI), .NGRP(NGRP)) mm_pd_i (
        .clk       (clk),
        .ext_rstb  (ext_rstb),
        .dec_valid (dec_valid),
        .dec_codes (dec_codes),
        .dec_bits  (dec_bits),
        .pd_offset (cfg.pd_offset),
        .pd_valid  (pd_valid),
        .pd_out    (pd_out)
    );

    loop_filter #(.NGRP(NGRP)) loop_filter_i (
        .clk      (clk),
        .ext_rstb (ext_rstb),
        .pd_valid (pd_valid),
        .pd_out   (pd_out),
        .kp_shift (cfg.kp_shift),
        .ki_shift (cfg.ki_shift),
        .loop_en  (cfg.loop_en),
        .pi_valid (pi_valid),
        .pi_code  (pi_code)
    );

endmodule

`default_nettype wire

/* verification/cdr_tb.sv */
`default_nettype none

module cdr_tb;
    import cdr_pkg::*;

    localparam int NTI  = 16;
    localparam int NGRP = 4;
    localparam int MAXN = 256;  // slots for expected values
    localparam int TMO  = 40;   // cycles allowed per wait

    typedef pd_val_t  [NGRP-1:0] pd_vec_t;
    typedef pi_code_t [NGRP-1:0] pi_vec_t;

    logic      clk = 1'b0;
    logic      ext_rstb;
    logic      in_valid;
    adc_code_t codes [NTI];
    logic      reg_valid;
    reg_req_t  reg_req;
    logic      rvalid;
    reg_data_t rdata;
    logic      pd_valid;
    pd_val_t   pd_out [NGRP];
    logic      pi_valid;
    pi_code_t  pi_code [NGRP];

    // reference model state
    adc_code_t      m_offset [NGRP];
    adc_code_t      m_thresh [NGRP];
    shift_t         m_kp;
    shift_t         m_ki;
    logic           m_loop_en;
    acc_t           m_integ [NGRP];
    pi_vec_t        m_pi;           // last interpolator codes
    int             cur_codes [NTI];
    logic [NTI-1:0] cur_bits;
    logic           prev_edge;      // bit NTI-1 of the batch before cur
    logic           have_cur;
    logic           have_prev;      // a batch sits before cur
    int             sent_n;

    // expected results indexed by output count
    pd_vec_t   exp_pd [MAXN];
    pi_vec_t   exp_pi [MAXN];
    reg_data_t exp_rd [MAXN];
    int        pd_exp_n;            // completed detector windows
    int        rd_exp_n;
    int        pd_seen;
    int        pi_seen;
    int        rd_seen;

    cdr_top #(.NTI(NTI), .NGRP(NGRP)) cdr_top_i (.*);

    always #50 clk = ~clk;

    // outputs are paired with expectations by count
    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pd_seen <= 0;
            pi_seen <= 0;
            rd_seen <= 0;
        end else begin
            if (pd_valid) pd_seen <= pd_seen + 1;
            if (pi_valid) pi_seen <= pi_seen + 1;
            if (rvalid) rd_seen <= rd_seen + 1;
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Error: %s is 0x%0h, expected 0x%0h", name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    quiet_in_reset: assert property (@(posedge clk)
        (!ext_rstb || $rose(ext_rstb)) |-> (!rvalid && !pd_valid && !pi_valid))
        else report_problem("a valid output was high in or right after reset");
    read_answered: assert property (@(posedge clk) disable iff (!ext_rstb)
        (reg_valid && !reg_req.we) |=> rvalid)
        else report_problem("read request got no rvalid one cycle later");
    read_only_on_req: assert property (@(posedge clk) disable iff (!ext_rstb)
        rvalid |-> $past(reg_valid && !reg_req.we))
        else report_problem("rvalid without a read request");
    read_data: assert property (@(posedge clk) disable iff (!ext_rstb)
        rvalid |-> rdata == exp_rd[rd_seen])
        else report_mismatch("rdata", $sampled(rdata), $sampled(exp_rd[rd_seen]));
    pd_no_extra: assert property (@(posedge clk) disable iff (!ext_rstb)
        pd_valid |-> pd_seen < pd_exp_n)
        else report_problem("pd_valid without a completed batch window");
    pi_no_extra: assert property (@(posedge clk) disable iff (!ext_rstb)
        pi_valid |-> pi_seen < pd_exp_n)
        else report_problem("pi_valid without a matching phase error");
    pi_follows_pd: assert property (@(posedge clk) disable iff (!ext_rstb)
        pd_valid |=> pi_valid)
        else report_problem("pi_valid did not follow pd_valid");

    for (genvar g = 0; g < NGRP; g++) begin : grp_chk
        pd_value: assert property (@(posedge clk) disable iff (!ext_rstb)
            pd_valid |-> pd_out[g] == exp_pd[pd_seen][g])
            else report_mismatch($sformatf("pd_out[%0d]", g), $sampled(pd_out[g]),
                                 $sampled(exp_pd[pd_seen][g]));
        pi_value: assert property (@(posedge clk) disable iff (!ext_rstb)
            pi_valid |-> pi_code[g] == exp_pi[pi_seen][g])
            else report_mismatch($sformatf("pi_code[%0d]", g), $sampled(pi_code[g]),
                                 $sampled(exp_pi[pi_seen][g]));
        pi_reset: assert property (@(posedge clk) !ext_rstb |-> pi_code[g] == '0)
            else report_mismatch($sformatf("pi_code[%0d]", g), $sampled(pi_code[g]), 0);
    end

    // one clock with inputs changing 10 after the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic int sgn(input logic b);
        return b ? 1 : -1;
    endfunction

    // pi rule with the integrator first and proportional on top
    function automatic void update_loop(input pd_vec_t pd);
        int e;
        for (int g = 0; g < NGRP; g++) begin
            if (m_loop_en) begin
                e          = int'($signed(pd[g]));
                m_integ[g] = acc_t'(int'(m_integ[g]) + (e >>> m_ki));  // 20 bit wrap
                m_pi[g]    = pi_code_t'((int'(m_integ[g]) + (e >>> m_kp)) >>> PI_FRAC);
            end
        end
        exp_pi[pd_exp_n] = m_pi;  // held codes when the loop is open
    endfunction

    function automatic reg_data_t expected_read(input reg_addr_t a);
        if (a < ADDR_THRESH0) return {8'h00, m_offset[a - ADDR_OFFSET0]};
        if (a < ADDR_GAIN) return {8'h00, m_thresh[a - ADDR_THRESH0]};
        if (a == ADDR_GAIN) return {8'h00, m_ki, m_kp};
        if (a == ADDR_CTRL) return {15'h0000, m_loop_en};
        if (a < ADDR_PI0 + NGRP) return {8'h00, m_pi[a - ADDR_PI0]};
        return '0;  // unmapped
    endfunction

    function automatic logic outputs_pending();
        return pd_seen != pd_exp_n || pi_seen != pd_exp_n || rd_seen != rd_exp_n;
    endfunction

    task automatic wait_outputs();
        int n;
        n = 0;
        while (outputs_pending() && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (outputs_pending()) report_problem("timed out waiting for DUT outputs");
        step();
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        reg_req.addr  = a;
        reg_req.wdata = d;
        reg_req.we    = 1'b1;
        reg_valid     = 1'b1;
        if (a < ADDR_THRESH0) m_offset[a - ADDR_OFFSET0] = d[7:0];
        else if (a < ADDR_GAIN) m_thresh[a - ADDR_THRESH0] = d[7:0];
        else if (a == ADDR_GAIN) begin
            m_kp = d[3:0];
            m_ki = d[7:4];
        end else if (a == ADDR_CTRL) m_loop_en = d[0];
        step();
        reg_valid = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a);
        reg_req.addr         = a;
        reg_req.wdata        = '0;
        reg_req.we           = 1'b0;
        reg_valid            = 1'b1;
        exp_rd[rd_exp_n]     = expected_read(a);
        rd_exp_n++;
        step();
        reg_valid = 1'b0;
        wait_outputs();
    endtask

    // new batch completes the window of the one before it
    task automatic send_batch(input int gap);
        adc_code_t      nb [NTI];
        logic [NTI-1:0] nbits;
        pd_vec_t        pd;
        int             a_prev;
        int             a_next;
        int             acc;
        repeat (gap) step();  // in_valid idle gap
        for (int s = 0; s < NTI; s++) begin
            nb[s]    = adc_code_t'($urandom);
            nbits[s] = int'(nb[s]) >= int'(m_thresh[s % NGRP]);
        end
        if (have_prev) begin
            for (int g = 0; g < NGRP; g++) begin
                acc = int'(m_offset[g]);
                for (int s = g; s < NTI; s += NGRP) begin
                    a_prev = (s == 0) ? sgn(prev_edge) : sgn(cur_bits[s-1]);
                    a_next = (s == NTI - 1) ? sgn(nbits[0]) : sgn(cur_bits[s+1]);
                    acc += cur_codes[s] * (a_next - a_prev);
                end
                pd[g] = pd_val_t'(acc);
            end
            exp_pd[pd_exp_n] = pd;
            update_loop(pd);
            pd_exp_n++;
        end
        prev_edge = cur_bits[NTI-1];
        cur_bits  = nbits;
        for (int s = 0; s < NTI; s++) cur_codes[s] = int'(nb[s]);
        have_prev = have_cur;
        have_cur  = 1'b1;
        sent_n++;
        codes    = nb;
        in_valid = 1'b1;
        step();
        in_valid = 1'b0;
    endtask

    task automatic run_batches(input int n);
        for (int i = 0; i < n; i++) send_batch($urandom_range(0, 3));
        wait_outputs();
    endtask

    task automatic read_pi_regs();
        for (int g = 0; g < NGRP; g++) read_reg(reg_addr_t'(ADDR_PI0 + g));
    endtask

    initial begin
        void'($urandom(32'h387b0679));
        ext_rstb  = 1'b1;
        in_valid  = 1'b0;
        reg_valid = 1'b0;
        reg_req   = '0;
        for (int s = 0; s < NTI; s++) codes[s] = '0;
        for (int g = 0; g < NGRP; g++) begin
            m_offset[g] = '0;
            m_thresh[g] = '0;
            m_integ[g]  = '0;
        end
        m_kp      = '0;
        m_ki      = '0;
        m_loop_en = 1'b0;
        m_pi      = '0;
        cur_bits  = '0;     // empty until the first batch
        prev_edge = 1'b0;
        have_cur  = 1'b0;
        have_prev = 1'b0;
        sent_n    = 0;
        pd_exp_n  = 0;
        rd_exp_n  = 0;
        #10 ext_rstb = 1'b0;
        repeat (5) @(posedge clk);
        #10 ext_rstb = 1'b1;
        read_pi_regs();     // zero right after reset
        // register map with random data and then every address read back
        for (int a = 0; a <= ADDR_CTRL; a++) write_reg(reg_addr_t'(a), reg_data_t'($urandom));
        for (int a = 0; a < 16; a++) read_reg(reg_addr_t'(a));
        // plain mm sums with the loop open
        for (int a = 0; a <= ADDR_CTRL; a++) write_reg(reg_addr_t'(a), '0);
        run_batches(12);
        // independent group thresholds and offsets
        for (int g = 0; g < NGRP; g++) begin
            write_reg(reg_addr_t'(ADDR_THRESH0 + g), reg_data_t'($urandom_range(0, 64) - 32));
            write_reg(reg_addr_t'(ADDR_OFFSET0 + g), reg_data_t'($urandom));
        end
        run_batches(12);
        // closed loop with a few gain settings
        write_reg(ADDR_CTRL, 16'h0001);
        repeat (3) begin
            write_reg(ADDR_GAIN, reg_data_t'($urandom_range(0, 255)));
            run_batches(10);
            read_pi_regs();
        end
        // open loop so the codes must freeze
        write_reg(ADDR_CTRL, 16'h0000);
        run_batches(8);
        read_pi_regs();
        if (pd_seen == sent_n - 2 && pi_seen == pd_seen) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_problem("pd_valid or pi_valid count does not match the batches sent");
        end
    end

endmodule

`default_nettype wire

/* all.f */
hdl/cdr_pkg.sv
hdl/data_slicer.sv
hdl/mm_pd.sv
hdl/loop_filter.sv
hdl/cdr_regs.sv
hdl/cdr_top.sv
verification/cdr_tb.sv

/* Bender.yml */
package:
  name: cdr_backend

sources:
  # package first, then the blocks, top level last
  - hdl/cdr_pkg.sv
  - hdl/data_slicer.sv
  - hdl/mm_pd.sv
  - hdl/loop_filter.sv
  - hdl/cdr_regs.sv
  - hdl/cdr_top.sv

  # testbench, top module cdr_tb
  - target: test
    files:
      - verification/cdr_tb.sv

dependencies: {}
